/* rtl/bmp_pkg.sv */
package bmp_pkg;

	// Plain vector types
	typedef logic [31:0] addr_t;
	typedef logic [31:0] pix_t;
	typedef logic [11:0] rgb_t;
	typedef logic [11:0] coord_t;
	typedef logic [3:0]  reg_addr_t;

	// Register map, byte offsets
	// CTRL: bit 0 enable, border colour in bits 27:16
	localparam reg_addr_t REG_CTRL = 4'd0;
	localparam reg_addr_t REG_BASE = 4'd4;
	// WIN: width 11:0, height 27:16
	localparam reg_addr_t REG_WIN  = 4'd8;
	// STAT: sticky underrun in bit 0 (write 1 clears), frame count 27:16
	localparam reg_addr_t REG_STAT = 4'd12;

	// Sync placement relative to end of active area
	localparam int HSYNC_OFS = 4;
	localparam int HSYNC_LEN = 8;
	localparam int VSYNC_OFS = 1;
	localparam int VSYNC_LEN = 2;

	// AXI4-Lite, master to slave
	typedef struct packed {
		logic        awvalid;
		reg_addr_t   awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		reg_addr_t   araddr;
		logic        rready;
	} axil_req_t;

	// AXI4-Lite, slave to master
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	// Read-only memory port
	typedef struct packed {
		logic  cyc;
		logic  stb;
		addr_t adr;
	} mem_req_t;

	typedef struct packed {
		logic ack;
		pix_t dat;
	} mem_rsp_t;

	// Settings handed from the register block to the datapath
	typedef struct packed {
		logic   enable;
		addr_t  base;
		coord_t win_w;
		coord_t win_h;
		rgb_t   border;
	} disp_cfg_t;

endpackage

/* rtl/bmp_regs.sv */
module bmp_regs (
	input  logic               clk40_i,
	input  logic               rst_i,
	input  bmp_pkg::axil_req_t s_axil_i,
	output bmp_pkg::axil_rsp_t s_axil_o,
	input  logic               underrun_i,
	input  logic               frame_start_i,
	output bmp_pkg::disp_cfg_t cfg_o
);
	typedef enum logic [1:0] {W_IDLE, W_ACK, W_RESP} wr_state_t;
	typedef enum logic [1:0] {R_IDLE, R_ACK, R_RESP} rd_state_t;

	wr_state_t       wr_state;
	rd_state_t       rd_state;
	logic            enable_q;
	bmp_pkg::rgb_t   border_q;
	bmp_pkg::addr_t  base_q;
	bmp_pkg::coord_t win_w_q;
	bmp_pkg::coord_t win_h_q;
	logic            underrun_q;
	bmp_pkg::coord_t frame_ctr_q;
	logic [31:0]     rdata_q;
	logic [31:0]     ctrl_cur;
	logic [31:0]     win_cur;
	logic [31:0]     stat_cur;
	logic [31:0]     ctrl_wr;
	logic [31:0]     base_wr;
	logic [31:0]     win_wr;
	logic            wr_fire;

	// Byte-lane merge of new write data into a register word
	function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
			input logic [31:0] wdat, input logic [3:0] strb);
		logic [31:0] res;
		res = cur;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = wdat[8*i +: 8];
		end
		return res;
	endfunction

	// Current register words as the bus sees them
	assign ctrl_cur = {4'b0, border_q, 15'b0, enable_q};
	assign win_cur  = {4'b0, win_h_q, 4'b0, win_w_q};
	assign stat_cur = {4'b0, frame_ctr_q, 15'b0, underrun_q};

	assign ctrl_wr = merge_bytes(ctrl_cur, s_axil_i.wdata, s_axil_i.wstrb);
	assign base_wr = merge_bytes(base_q, s_axil_i.wdata, s_axil_i.wstrb);
	assign win_wr  = merge_bytes(win_cur, s_axil_i.wdata, s_axil_i.wstrb);

	// Address and data accepted in the W_ACK cycle
	assign wr_fire = (wr_state == W_ACK);

	// Write channel, waits for both valids before accepting
	always_ff @(posedge clk40_i) begin
		if (rst_i) begin
			wr_state <= W_IDLE;
		end else begin
			case (wr_state)
				W_IDLE: if (s_axil_i.awvalid && s_axil_i.wvalid) wr_state <= W_ACK;
				W_ACK:  wr_state <= W_RESP;
				W_RESP: if (s_axil_i.bready) wr_state <= W_IDLE;
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	// Read channel
	always_ff @(posedge clk40_i) begin
		if (rst_i) begin
			rd_state <= R_IDLE;
		end else begin
			case (rd_state)
				R_IDLE: if (s_axil_i.arvalid) rd_state <= R_ACK;
				R_ACK:  rd_state <= R_RESP;
				R_RESP: if (s_axil_i.rready) rd_state <= R_IDLE;
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	// Read data captured on the address handshake
	always_ff @(posedge clk40_i) begin
		if (rd_state == R_ACK) begin
			case (s_axil_i.araddr)
				bmp_pkg::REG_CTRL: rdata_q <= ctrl_cur;
				bmp_pkg::REG_BASE: rdata_q <= base_q;
				bmp_pkg::REG_WIN:  rdata_q <= win_cur;
				bmp_pkg::REG_STAT: rdata_q <= stat_cur;
				default:           rdata_q <= '0;
			endcase
		end
	end

	// Control registers
	always_ff @(posedge clk40_i) begin
		if (rst_i) begin
			enable_q    <= 1'b0;
			border_q    <= '0;
			base_q      <= '0;
			win_w_q     <= '0;
			win_h_q     <= '0;
			underrun_q  <= 1'b0;
			frame_ctr_q <= '0;
		end else begin
			if (wr_fire && s_axil_i.awaddr == bmp_pkg::REG_CTRL) begin
				enable_q <= ctrl_wr[0];
				border_q <= ctrl_wr[27:16];
			end
			if (wr_fire && s_axil_i.awaddr == bmp_pkg::REG_BASE)
				base_q <= base_wr;
			if (wr_fire && s_axil_i.awaddr == bmp_pkg::REG_WIN) begin
				win_w_q <= win_wr[11:0];
				win_h_q <= win_wr[27:16];
			end
			// New underrun wins over a clear in the same cycle
			if (underrun_i)
				underrun_q <= 1'b1;
			else if (wr_fire && s_axil_i.awaddr == bmp_pkg::REG_STAT &&
					s_axil_i.wstrb[0] && s_axil_i.wdata[0])
				underrun_q <= 1'b0;
			// Wraps at 4096
			if (frame_start_i)
				frame_ctr_q <= frame_ctr_q + 1'b1;
		end
	end

	always_comb begin
		s_axil_o.awready = wr_fire;
		s_axil_o.wready  = wr_fire;
		s_axil_o.bvalid  = (wr_state == W_RESP);
		s_axil_o.bresp   = 2'b00;
		s_axil_o.arready = (rd_state == R_ACK);
		s_axil_o.rvalid  = (rd_state == R_RESP);
		s_axil_o.rdata   = rdata_q;
		s_axil_o.rresp   = 2'b00;
	end

	always_comb begin
		cfg_o.enable = enable_q;
		cfg_o.base   = base_q;
		cfg_o.win_w  = win_w_q;
		cfg_o.win_h  = win_h_q;
		cfg_o.border = border_q;
	end

	// Responses held until the master takes them
	a_bvalid_hold: assert property (@(posedge clk40_i) disable iff (rst_i)
		s_axil_o.bvalid && !s_axil_i.bready |=> s_axil_o.bvalid);
	a_rvalid_hold: assert property (@(posedge clk40_i) disable iff (rst_i)
		s_axil_o.rvalid && !s_axil_i.rready |=> s_axil_o.rvalid);

endmodule

/* rtl/video_timing.sv */
module video_timing #(
	parameter int HACT = 32,
	parameter int HTOT = 64,
	parameter int VACT = 12,
	parameter int VTOT = 16
) (
	input  logic            clk40_i,
	input  logic            rst_i,
	input  bmp_pkg::coord_t win_w_i,
	input  bmp_pkg::coord_t win_h_i,
	output bmp_pkg::coord_t hctr_o,
	output bmp_pkg::coord_t vctr_o,
	output logic            frame_start_o,
	output logic            hsync_o,
	output logic            vsync_o,
	output logic            active_o,
	output logic            in_window_o
);
	bmp_pkg::coord_t hctr_q;
	bmp_pkg::coord_t vctr_q;
	logic            h_wrap;
	logic            v_wrap;

	assign h_wrap = (hctr_q == bmp_pkg::coord_t'(HTOT - 1));
	assign v_wrap = (vctr_q == bmp_pkg::coord_t'(VTOT - 1));

	// Dot counter every clock, line counter on dot wrap
	always_ff @(posedge clk40_i) begin
		if (rst_i) begin
			hctr_q <= '0;
			vctr_q <= '0;
		end else if (h_wrap) begin
			hctr_q <= '0;
			vctr_q <= v_wrap ? '0 : vctr_q + 1'b1;
		end else begin
			hctr_q <= hctr_q + 1'b1;
		end
	end

	assign hctr_o = hctr_q;
	assign vctr_o = vctr_q;

	// Frame boundary sits at the first dot of vertical sync
	// so the fetch engine has the remaining blank lines to prefill
	assign frame_start_o = (hctr_q == '0) &&
		(vctr_q == bmp_pkg::coord_t'(VACT + bmp_pkg::VSYNC_OFS));

	// Sync pulses
	assign hsync_o = (hctr_q >= bmp_pkg::coord_t'(HACT + bmp_pkg::HSYNC_OFS)) &&
		(hctr_q < bmp_pkg::coord_t'(HACT + bmp_pkg::HSYNC_OFS + bmp_pkg::HSYNC_LEN));
	assign vsync_o = (vctr_q >= bmp_pkg::coord_t'(VACT + bmp_pkg::VSYNC_OFS)) &&
		(vctr_q < bmp_pkg::coord_t'(VACT + bmp_pkg::VSYNC_OFS + bmp_pkg::VSYNC_LEN));

	assign active_o = (hctr_q < bmp_pkg::coord_t'(HACT)) &&
		(vctr_q < bmp_pkg::coord_t'(VACT));
	// Window anchored at top left of the active area
	assign in_window_o = active_o && (hctr_q < win_w_i) && (vctr_q < win_h_i);

	a_hctr_range: assert property (@(posedge clk40_i) disable iff (rst_i)
		hctr_q < bmp_pkg::coord_t'(HTOT));

endmodule

/* rtl/bmp_fetch.sv */
module bmp_fetch #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic               clk40_i,
	input  logic               rst_i,
	input  bmp_pkg::disp_cfg_t cfg_i,
	input  logic               frame_start_i,
	input  logic               pop_i,
	output bmp_pkg::mem_req_t  m_mem_o,
	input  bmp_pkg::mem_rsp_t  m_mem_i,
	output logic               empty_o,
	output bmp_pkg::pix_t      dat_o
);
	// Depth is a power of two, pointers wrap on their own
	localparam int PW = $clog2(FIFO_DEPTH);

	typedef logic [23:0]   words_t;
	typedef logic [PW-1:0] ptr_t;
	typedef logic [PW:0]   fill_t;
	typedef enum logic [1:0] {F_IDLE, F_REQ, F_DONE} fetch_state_t;

	fetch_state_t   state;
	logic           restart_q;
	bmp_pkg::addr_t snap_base;
	words_t         snap_words;
	bmp_pkg::addr_t adr_q;
	words_t         words_q;
	bmp_pkg::pix_t  fifo_mem [FIFO_DEPTH];
	ptr_t           wr_ptr;
	ptr_t           rd_ptr;
	fill_t          fill_q;
	logic           push;
	logic           pop;
	logic           more;

	// Word from a request issued before a flush is dropped
	assign push = (state == F_REQ) && m_mem_i.ack && !restart_q && !frame_start_i;
	assign pop  = pop_i && (fill_q != '0);
	// Room for one more in flight after this push
	assign more = (words_q > words_t'(1)) && (fill_q < fill_t'(FIFO_DEPTH - 1));

	// Frame snapshot, nothing to fetch while disabled
	always_ff @(posedge clk40_i) begin
		if (frame_start_i) begin
			snap_base  <= cfg_i.base;
			snap_words <= cfg_i.enable ? words_t'(cfg_i.win_w) * words_t'(cfg_i.win_h) : '0;
		end
	end

	// Fetch FSM
	always_ff @(posedge clk40_i) begin
		if (rst_i) begin
			state     <= F_IDLE;
			restart_q <= 1'b0;
			adr_q     <= '0;
			words_q   <= '0;
		end else begin
			case (state)
				F_IDLE: begin
					if (restart_q) begin
						adr_q     <= snap_base;
						words_q   <= snap_words;
						restart_q <= 1'b0;
					end else if (words_q == '0) begin
						state <= F_DONE;
					end else if (fill_q < fill_t'(FIFO_DEPTH)) begin
						state <= F_REQ;
					end
				end
				F_REQ: begin
					// adr held until ack
					if (m_mem_i.ack) begin
						if (push) begin
							adr_q   <= adr_q + 1'b1;
							words_q <= words_q - 1'b1;
						end
						if (!push || !more)
							state <= F_IDLE;
					end
				end
				F_DONE: if (restart_q) state <= F_IDLE;
				default: state <= F_IDLE;
			endcase
			// Last so a new frame always wins over the clear above
			if (frame_start_i)
				restart_q <= 1'b1;
		end
	end

	// FIFO storage
	always_ff @(posedge clk40_i) begin
		if (push)
			fifo_mem[wr_ptr] <= m_mem_i.dat;
	end

	// Pointers and fill level, flushed at each frame
	always_ff @(posedge clk40_i) begin
		if (rst_i || frame_start_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill_q <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			fill_q <= fill_q + fill_t'(push) - fill_t'(pop);
		end
	end

	always_comb begin
		m_mem_o.cyc = (state == F_REQ);
		m_mem_o.stb = (state == F_REQ);
		m_mem_o.adr = adr_q;
	end

	assign empty_o = (fill_q == '0);
	assign dat_o   = fifo_mem[rd_ptr];

	a_adr_stable: assert property (@(posedge clk40_i) disable iff (rst_i)
		m_mem_o.stb && !m_mem_i.ack |=> m_mem_o.stb && $stable(m_mem_o.adr));
	a_no_overflow: assert property (@(posedge clk40_i) disable iff (rst_i)
		push |-> fill_q < fill_t'(FIFO_DEPTH));

endmodule

/* rtl/bmp_pixel_out.sv */
module bmp_pixel_out (
	input  logic               clk40_i,
	input  logic               rst_i,
	input  bmp_pkg::disp_cfg_t cfg_i,
	input  logic               active_i,
	input  logic               in_window_i,
	input  logic               hsync_i,
	input  logic               vsync_i,
	input  logic               fifo_empty_i,
	input  bmp_pkg::pix_t      fifo_dat_i,
	output logic               fifo_pop_o,
	output logic               underrun_o,
	output bmp_pkg::rgb_t      rgb_o,
	output logic               hsync_o,
	output logic               vsync_o,
	output logic               blank_o
);
	logic          want_pix;
	bmp_pkg::rgb_t rgb_d;

	// One bitmap word per window dot
	assign want_pix   = cfg_i.enable && in_window_i;
	assign fifo_pop_o = want_pix && !fifo_empty_i;
	assign underrun_o = want_pix && fifo_empty_i;

	// Black in blanking, border on a missing pixel
	always_comb begin
		if (!active_i)
			rgb_d = '0;
		else if (fifo_pop_o)
			rgb_d = {fifo_dat_i[23:20], fifo_dat_i[15:12], fifo_dat_i[7:4]};
		else
			rgb_d = cfg_i.border;
	end

	// All pins registered, one dot behind the counters
	always_ff @(posedge clk40_i) begin
		if (rst_i) begin
			rgb_o   <= '0;
			hsync_o <= 1'b0;
			vsync_o <= 1'b0;
			blank_o <= 1'b1;
		end else begin
			rgb_o   <= rgb_d;
			hsync_o <= hsync_i;
			vsync_o <= vsync_i;
			blank_o <= !active_i;
		end
	end

endmodule

/* rtl/bmp_display_top.sv */
module bmp_display_top #(
	parameter int HACT       = 32,
	parameter int HTOT       = 64,
	parameter int VACT       = 12,
	parameter int VTOT       = 16,
	parameter int FIFO_DEPTH = 16
) (
	input  logic               clk40_i,
	input  logic               rst_i,
	input  bmp_pkg::axil_req_t s_axil_i,
	output bmp_pkg::axil_rsp_t s_axil_o,
	output bmp_pkg::mem_req_t  m_mem_o,
	input  bmp_pkg::mem_rsp_t  m_mem_i,
	output bmp_pkg::rgb_t      rgb_o,
	output logic               hsync_o,
	output logic               vsync_o,
	output logic               blank_o
);
	bmp_pkg::disp_cfg_t cfg;
	logic               frame_start;
	logic               hsync;
	logic               vsync;
	logic               active;
	logic               in_window;
	logic               fifo_empty;
	bmp_pkg::pix_t      fifo_dat;
	logic               fifo_pop;
	logic               underrun;

	// CPU side registers
	bmp_regs u_regs (
		.clk40_i       (clk40_i),
		.rst_i         (rst_i),
		.s_axil_i      (s_axil_i),
		.s_axil_o      (s_axil_o),
		.underrun_i    (underrun),
		.frame_start_i (frame_start),
		.cfg_o         (cfg)
	);

	// Counters left open, only the decoded flags are used here
	video_timing #(
		.HACT (HACT),
		.HTOT (HTOT),
		.VACT (VACT),
		.VTOT (VTOT)
	) u_timing (
		.clk40_i       (clk40_i),
		.rst_i         (rst_i),
		.win_w_i       (cfg.win_w),
		.win_h_i       (cfg.win_h),
		.hctr_o        (),
		.vctr_o        (),
		.frame_start_o (frame_start),
		.hsync_o       (hsync),
		.vsync_o       (vsync),
		.active_o      (active),
		.in_window_o   (in_window)
	);

	// Memory reader and pixel queue
	bmp_fetch #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fetch (
		.clk40_i       (clk40_i),
		.rst_i         (rst_i),
		.cfg_i         (cfg),
		.frame_start_i (frame_start),
		.pop_i         (fifo_pop),
		.m_mem_o       (m_mem_o),
		.m_mem_i       (m_mem_i),
		.empty_o       (fifo_empty),
		.dat_o         (fifo_dat)
	);

	// Video pins
	bmp_pixel_out u_out (
		.clk40_i      (clk40_i),
		.rst_i        (rst_i),
		.cfg_i        (cfg),
		.active_i     (active),
		.in_window_i  (in_window),
		.hsync_i      (hsync),
		.vsync_i      (vsync),
		.fifo_empty_i (fifo_empty),
		.fifo_dat_i   (fifo_dat),
		.fifo_pop_o   (fifo_pop),
		.underrun_o   (underrun),
		.rgb_o        (rgb_o),
		.hsync_o      (hsync_o),
		.vsync_o      (vsync_o),
		.blank_o      (blank_o)
	);

endmodule

/* dv/bmp_checker.sv */
module bmp_checker #(
	parameter int HACT = 32,
	parameter int HTOT = 64,
	parameter int VACT = 12
) (
	input  logic               clk40_i,
	input  logic               rst_i,
	input  bmp_pkg::axil_req_t s_axil_i,
	input  bmp_pkg::axil_rsp_t s_axil_o,
	input  bmp_pkg::mem_req_t  m_mem_o,
	input  bmp_pkg::rgb_t      rgb_i,
	input  logic               hsync_i,
	input  logic               vsync_i,
	input  logic               blank_i,
	input  bmp_pkg::disp_cfg_t cfg_i,
	input  bmp_pkg::reg_addr_t exp_addr_i,
	input  logic [31:0]        exp_rdata_i,
	input  logic [127:0]       test_name_i,
	output int                 err_cnt_o
);
	// Config in force for the frame on screen
	bmp_pkg::disp_cfg_t cur;
	logic               prev_en;
	logic               prev_hs;
	logic               prev_vs;
	logic               prev_blank;
	logic               seen_vsync;
	int                 x;
	int                 y;
	int                 hs_len;
	int                 vs_len;
	int                 vs_count;

	// Model word layout, colour nibbles at 23:20, 15:12, 7:4
	function automatic bmp_pkg::rgb_t word_colour(input bmp_pkg::pix_t w);
		return {w[23:20], w[15:12], w[7:4]};
	endfunction

	function automatic bmp_pkg::rgb_t expected_dot(input bmp_pkg::disp_cfg_t c,
			input int px, input int py);
		bmp_pkg::addr_t a;
		if (!c.enable || px >= int'(c.win_w) || py >= int'(c.win_h))
			return c.border;
		a = c.base + bmp_pkg::addr_t'(py) * bmp_pkg::addr_t'(c.win_w) +
			bmp_pkg::addr_t'(px);
		return word_colour(a * 32'h0010_1010);
	endfunction

	// Live enable, window and border must match the frame snapshot
	function automatic logic cfg_settled(input bmp_pkg::disp_cfg_t c);
		return c.enable == cur.enable && c.win_w == cur.win_w &&
			c.win_h == cur.win_h && c.border == cur.border;
	endfunction

	always @(negedge clk40_i) begin
		logic [31:0]   exp_word;
		bmp_pkg::rgb_t exp_rgb;
		if (rst_i) begin
			cur        = '0;
			prev_en    = 1'b0;
			prev_hs    = 1'b0;
			prev_vs    = 1'b0;
			prev_blank = 1'b1;
			seen_vsync = 1'b0;
			x          = 0;
			y          = 0;
			hs_len     = 0;
			vs_len     = 0;
			vs_count   = 0;
			err_cnt_o  = 0;
		end else begin
			// Bus responses
			if (s_axil_o.bvalid && s_axil_i.bready && s_axil_o.bresp != 2'b00) begin
				$display("Write response for %0s is not OKAY", test_name_i);
				err_cnt_o++;
			end
			if (s_axil_o.rvalid && s_axil_i.rready) begin
				exp_word = exp_rdata_i;
				// Frame count field follows counted vsync edges
				if (exp_addr_i == bmp_pkg::REG_STAT)
					exp_word[27:16] = vs_count[11:0];
				if (s_axil_o.rresp != 2'b00) begin
					$display("Read response for %0s is not OKAY", test_name_i);
					err_cnt_o++;
				end
				if (s_axil_o.rdata != exp_word) begin
					$display("MISMATCH %0s: expected %h, actual %h",
						test_name_i, exp_word, s_axil_o.rdata);
					err_cnt_o++;
				end
			end
			// Nothing fetched once disabled for a full frame
			if (m_mem_o.stb && !cfg_i.enable && !cur.enable && !prev_en) begin
				$display("Memory read at %h while display disabled (%0s)",
					m_mem_o.adr, test_name_i);
				err_cnt_o++;
			end
			// Frame boundary
			if (vsync_i && !prev_vs) begin
				if (seen_vsync && y != VACT) begin
					$display("Frame had %0d active lines instead of %0d (%0s)",
						y, VACT, test_name_i);
					err_cnt_o++;
				end
				seen_vsync = 1'b1;
				y          = 0;
				vs_count++;
				prev_en    = cur.enable;
				cur        = cfg_i;
			end
			if (!vsync_i && prev_vs && vs_len != bmp_pkg::VSYNC_LEN * HTOT) begin
				$display("Vertical sync lasted %0d dots (%0s)", vs_len, test_name_i);
				err_cnt_o++;
			end
			vs_len = vsync_i ? vs_len + 1 : 0;
			// Horizontal sync width
			if (!hsync_i && prev_hs && hs_len != bmp_pkg::HSYNC_LEN) begin
				$display("Horizontal sync lasted %0d dots (%0s)", hs_len, test_name_i);
				err_cnt_o++;
			end
			hs_len = hsync_i ? hs_len + 1 : 0;
			// Active dots
			if (!blank_i) begin
				exp_rgb = expected_dot(cur, x, y);
				if (cfg_settled(cfg_i) && rgb_i != exp_rgb) begin
					$display("MISMATCH %0s: expected %h, actual %h at dot %0d line %0d",
						test_name_i, exp_rgb, rgb_i, x, y);
					err_cnt_o++;
				end
				x++;
			end
			if (blank_i && !prev_blank) begin
				if (x != HACT) begin
					$display("Line had %0d active dots instead of %0d (%0s)",
						x, HACT, test_name_i);
					err_cnt_o++;
				end
				x = 0;
				y++;
			end
			prev_hs    = hsync_i;
			prev_vs    = vsync_i;
			prev_blank = blank_i;
		end
	end

endmodule

/* dv/tb_bmp_display.sv */
module tb_bmp_display;

	localparam int HACT       = 32;
	localparam int HTOT       = 64;
	localparam int VACT       = 12;
	localparam int VTOT       = 16;
	localparam int FIFO_DEPTH = 16;
	// Wait limits in clock cycles
	localparam int HS_LIMIT    = 200;
	localparam int FRAME_LIMIT = 2 * HTOT * VTOT;

	logic                clk40_i;
	logic                rst_i;
	bmp_pkg::axil_req_t  s_axil_i;
	bmp_pkg::axil_rsp_t  s_axil_o;
	bmp_pkg::mem_req_t   m_mem_o;
	bmp_pkg::mem_rsp_t   m_mem_i = '0;
	bmp_pkg::rgb_t       rgb_o;
	logic                hsync_o;
	logic                vsync_o;
	logic                blank_o;

	// Expected state handed to the checker
	bmp_pkg::disp_cfg_t  cfg_shadow;
	bmp_pkg::reg_addr_t  exp_addr;
	logic [31:0]         exp_rdata;
	logic [127:0]        test_name;
	int                  chk_errs;
	int                  stim_errs;
	int                  timeouts;

	// Memory model state
	int                  seed = 32'h609b_23a6;
	int                  mem_wait;
	logic                mem_busy;

	bmp_display_top #(
		.HACT       (HACT),
		.HTOT       (HTOT),
		.VACT       (VACT),
		.VTOT       (VTOT),
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut0 (
		.clk40_i  (clk40_i),
		.rst_i    (rst_i),
		.s_axil_i (s_axil_i),
		.s_axil_o (s_axil_o),
		.m_mem_o  (m_mem_o),
		.m_mem_i  (m_mem_i),
		.rgb_o    (rgb_o),
		.hsync_o  (hsync_o),
		.vsync_o  (vsync_o),
		.blank_o  (blank_o)
	);

	bmp_checker #(
		.HACT (HACT),
		.HTOT (HTOT),
		.VACT (VACT)
	) chk0 (
		.clk40_i     (clk40_i),
		.rst_i       (rst_i),
		.s_axil_i    (s_axil_i),
		.s_axil_o    (s_axil_o),
		.m_mem_o     (m_mem_o),
		.rgb_i       (rgb_o),
		.hsync_i     (hsync_o),
		.vsync_i     (vsync_o),
		.blank_i     (blank_o),
		.cfg_i       (cfg_shadow),
		.exp_addr_i  (exp_addr),
		.exp_rdata_i (exp_rdata),
		.test_name_i (test_name),
		.err_cnt_o   (chk_errs)
	);

	initial begin
		clk40_i = 1'b0;
		forever #20 clk40_i = ~clk40_i;
	end

	// Memory answers 1 to 4 cycles after the strobe
	// Ack lasts one cycle
	always @(posedge clk40_i) begin
		if (rst_i) begin
			m_mem_i.ack <= 1'b0;
			m_mem_i.dat <= '0;
			mem_busy = 1'b0;
			mem_wait = 0;
		end else if (m_mem_i.ack) begin
			m_mem_i.ack <= 1'b0;
		end else if (m_mem_o.cyc && m_mem_o.stb) begin
			if (!mem_busy) begin
				mem_wait = $random(seed) & 3;
				mem_busy = 1'b1;
			end
			if (mem_wait == 0) begin
				m_mem_i.ack <= 1'b1;
				m_mem_i.dat <= m_mem_o.adr * 32'h0010_1010;
				mem_busy = 1'b0;
			end else begin
				mem_wait = mem_wait - 1;
			end
		end
	end

	task automatic report_timeout(input string what);
		$display("TIMEOUT: %s did not happen in time", what);
		timeouts++;
	endtask

	task automatic axil_write(input bmp_pkg::reg_addr_t a, input logic [31:0] d);
		int n;
		@(posedge clk40_i);
		s_axil_i.awvalid <= 1'b1;
		s_axil_i.awaddr  <= a;
		s_axil_i.wvalid  <= 1'b1;
		s_axil_i.wdata   <= d;
		s_axil_i.wstrb   <= 4'hf;
		n = 0;
		@(negedge clk40_i);
		while (!s_axil_o.awready && n < HS_LIMIT) begin
			n++;
			@(negedge clk40_i);
		end
		if (!s_axil_o.awready)
			report_timeout("write address handshake");
		@(posedge clk40_i);
		s_axil_i.awvalid <= 1'b0;
		s_axil_i.wvalid  <= 1'b0;
		// Shadow of what the DUT now holds
		case (a)
			bmp_pkg::REG_CTRL: begin
				cfg_shadow.enable <= d[0];
				cfg_shadow.border <= d[27:16];
			end
			bmp_pkg::REG_BASE: cfg_shadow.base <= d;
			bmp_pkg::REG_WIN: begin
				cfg_shadow.win_w <= d[11:0];
				cfg_shadow.win_h <= d[27:16];
			end
			default: ;
		endcase
		n = 0;
		@(negedge clk40_i);
		while (!s_axil_o.bvalid && n < HS_LIMIT) begin
			n++;
			@(negedge clk40_i);
		end
		if (!s_axil_o.bvalid)
			report_timeout("write response");
		@(posedge clk40_i);
	endtask

	// Checker compares rdata in the rvalid cycle
	task automatic axil_read(input bmp_pkg::reg_addr_t a, input logic [31:0] d);
		int n;
		@(posedge clk40_i);
		exp_addr         <= a;
		exp_rdata        <= d;
		s_axil_i.arvalid <= 1'b1;
		s_axil_i.araddr  <= a;
		n = 0;
		@(negedge clk40_i);
		while (!s_axil_o.arready && n < HS_LIMIT) begin
			n++;
			@(negedge clk40_i);
		end
		if (!s_axil_o.arready)
			report_timeout("read address handshake");
		@(posedge clk40_i);
		s_axil_i.arvalid <= 1'b0;
		n = 0;
		@(negedge clk40_i);
		while (!s_axil_o.rvalid && n < HS_LIMIT) begin
			n++;
			@(negedge clk40_i);
		end
		if (!s_axil_o.rvalid)
			report_timeout("read data");
		@(posedge clk40_i);
	endtask

	// Frame boundary is the vsync_o rising edge
	task automatic run_frames(input int count);
		int n;
		logic prev_vs;
		for (int i = 0; i < count; i++) begin
			n = 0;
			@(negedge clk40_i);
			prev_vs = vsync_o;
			@(negedge clk40_i);
			while (!(vsync_o && !prev_vs) && n < FRAME_LIMIT) begin
				n++;
				prev_vs = vsync_o;
				@(negedge clk40_i);
			end
			if (!(vsync_o && !prev_vs))
				report_timeout("vertical sync");
		end
	endtask

	task automatic run_stimulus(input int fd);
		string        line;
		int           rc;
		logic [127:0] name_v;
		logic [7:0]   cmd_v;
		logic [3:0]   addr_v;
		logic [31:0]  data_v;
		// Stop at the first lost handshake or frame
		while (!$feof(fd) && timeouts == 0) begin
			rc = $fgets(line, fd);
			if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
				rc = $sscanf(line, "%s %s %h %h", name_v, cmd_v, addr_v, data_v);
				if (rc == 4) begin
					test_name <= name_v;
					case (cmd_v)
						"W": axil_write(addr_v, data_v);
						"R": axil_read(addr_v, data_v);
						"F": run_frames(int'(data_v));
						default: begin
							$display("Unknown stimulus command in line: %s", line);
							stim_errs++;
						end
					endcase
				end
			end
		end
	endtask

	initial begin
		int fd;
		rst_i      = 1'b1;
		s_axil_i   = '0;
		s_axil_i.bready = 1'b1;
		s_axil_i.rready = 1'b1;
		cfg_shadow = '0;
		exp_addr   = '0;
		exp_rdata  = '0;
		test_name  = '0;
		stim_errs  = 0;
		timeouts   = 0;
		repeat (5) @(posedge clk40_i);
		rst_i <= 1'b0;
		fd = $fopen("dv/bmp_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file dv/bmp_stim.txt");
			$display("Regression failed");
			$finish;
		end else begin
			run_stimulus(fd);
			$fclose(fd);
			repeat (4) @(posedge clk40_i);
			$display("Errors: %0d from checker, %0d from stimulus, %0d timeouts",
				chk_errs, stim_errs, timeouts);
			if (chk_errs == 0 && stim_errs == 0 && timeouts == 0)
				$display("Regression passed");
			else
				$display("Regression failed");
			$finish;
		end
	end

endmodule

/* dv/bmp_stim.txt */
# name cmd addr data : W writes data, R reads and expects data, F runs data frames
# STAT reads take the frame count from the checker, the stim gives bits 0 and 15:0
reset_rd R 0 00000000
dis_win W 8 00080010
dis_base W 4 00000100
dis_brd W 0 0abc0000
dis_run F 0 00000002
reg_win R 8 00080010
reg_base R 4 00000100
win_en W 0 0abc0001
win_run F 0 00000001
win_clr W c 00000001
win_frames F 0 00000002
stat_rd R c 00000000
base_chg W 4 00000400
base_run F 0 00000002
stat_end R c 00000000
ctrl_rd R 0 0abc0001

/* compile.f */
rtl/bmp_pkg.sv
rtl/bmp_regs.sv
rtl/video_timing.sv
rtl/bmp_fetch.sv
rtl/bmp_pixel_out.sv
rtl/bmp_display_top.sv
dv/bmp_checker.sv
dv/tb_bmp_display.sv

/* run.sh */
#!/bin/sh
# Build and run the bitmap display testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f \
	--top-module tb_bmp_display -o sim_bmp
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_bmp > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
	exit 0
fi
exit 1
